// File: design/shift_buffer_pkg.sv
// shift buffer package: sizes, widths, row/beat types, configuration and tag structs
package shift_buffer_pkg;

    // pixel and array sizes
    localparam int DATA_WIDTH   = 16;   // bits per pixel word
    localparam int CONV_UNITS   = 8;    // words per output beat
    localparam int KERNEL_H_MAX = 3;
    localparam int KERNEL_W_MAX = 3;

    // padded row carries the extra words needed for the tallest kernel
    localparam int ROW_WORDS = CONV_UNITS + KERNEL_H_MAX - 1;   // 10 words

    // widths of the "minus one" kernel fields
    localparam int KERNEL_H_WIDTH = $clog2(KERNEL_H_MAX + 1);   // 2
    localparam int KERNEL_W_WIDTH = $clog2(KERNEL_W_MAX + 1);   // 2

    // counter widths
    localparam int CIN_WIDTH    = 10;
    localparam int BLOCKS_WIDTH = 10;

    // one pixel word
    typedef logic [DATA_WIDTH-1:0] pixel_t;

    // padded input row, word 0 in the low bits
    typedef pixel_t [ROW_WORDS-1:0] row_t;

    // one output beat, word 0 in the low bits
    typedef pixel_t [CONV_UNITS-1:0] beat_t;

    // job configuration, sampled on start
    // every *_1 field is the real value minus one
    typedef struct packed {
        logic [KERNEL_H_WIDTH-1:0] kernel_h_1;
        logic [KERNEL_W_WIDTH-1:0] kernel_w_1;
        logic                      is_max;     // passed through to tag
        logic                      is_relu;    // passed through to tag
        logic [CIN_WIDTH-1:0]      cin_1;      // input channels per group
        logic [BLOCKS_WIDTH-1:0]   blocks_1;   // blocks per job
    } conv_cfg_t;   // 26 bits

    // user word sent with every beat
    // declared msb first so is_1x1 lands on bit 0, is_blocks_2 on bit 3
    typedef struct packed {
        logic is_blocks_2;   // block before last (depends on kernel_w)
        logic is_relu;
        logic is_max;
        logic is_1x1;        // kernel_h == 1
    } beat_tag_t;   // 4 bits

    // shifter output: one beat plus end-of-row marker
    typedef struct packed {
        beat_t data;
        logic  last_shift;   // final shifted copy of this row
    } shift_beat_t;   // 129 bits

    // configuration seen after reset: 2x2 kernel fields, everything else zero
    localparam conv_cfg_t CFG_RESET = '{
        kernel_h_1: KERNEL_H_WIDTH'(1),
        kernel_w_1: KERNEL_W_WIDTH'(1),
        is_max:     1'b0,
        is_relu:    1'b0,
        cin_1:      '0,
        blocks_1:   '0
    };

endpackage

// File: design/row_skid_buffer.sv
// row_skid_buffer: two-entry skid buffer with registered input ready for padded rows
`timescale 1ns/1ps

module row_skid_buffer (
    input  logic                   aclk,
    input  logic                   rst_n,
    // upstream row stream
    input  shift_buffer_pkg::row_t s_row,
    input  logic                   s_valid,
    output logic                   s_ready,     // flop, high while skid entry empty
    // row to shifter
    output shift_buffer_pkg::row_t row,
    output logic                   row_valid,
    input  logic                   row_ready
);

    shift_buffer_pkg::row_t skid_row;     // overflow entry
    logic                   skid_valid;

    logic in_fire;          // row accepted from upstream
    logic out_free;         // output entry empty or draining this cycle
    logic skid_valid_next;
    logic row_valid_next;

    assign in_fire  = s_valid && s_ready;
    assign out_free = !row_valid || row_ready;

    // skid entry fills only when the output is stuck and a row arrives
    // it drains into the output entry as soon as that frees up
    assign skid_valid_next = !out_free && (skid_valid || in_fire);

    // output stays full when stuck, else refilled from skid first, then input
    assign row_valid_next = out_free ? (skid_valid || in_fire) : 1'b1;

    // control flops
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            row_valid  <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b1;   // empty after reset
        end else begin
            row_valid  <= row_valid_next;
            skid_valid <= skid_valid_next;
            s_ready    <= !skid_valid_next;   // one free entry keeps us ready
        end
    end

    // payload flops
    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (skid_valid) begin
                row <= skid_row;   // older row goes first, keeps order
            end else if (in_fire) begin
                row <= s_row;      // straight through
            end
        end
        if (in_fire && !out_free) begin
            skid_row <= s_row;     // park while output stalls
        end
    end

endmodule

// File: design/row_shifter.sv
// row_shifter: holds one padded row and emits kernel_h shifted beats with a last-shift mark
`timescale 1ns/1ps

module row_shifter (
    input  logic                                          aclk,
    input  logic                                          rst_n,
    // padded row in
    input  shift_buffer_pkg::row_t                        row,
    input  logic                                          row_valid,
    output logic                                          row_ready,
    // kernel height minus one, from captured config
    input  logic [shift_buffer_pkg::KERNEL_H_WIDTH-1:0]   kernel_h_1,
    // shifted beats out
    output shift_buffer_pkg::shift_beat_t                 shift,
    output logic                                          shift_valid,
    input  logic                                          shift_ready
);

    // row register, word 0 always at the bottom of the current beat
    shift_buffer_pkg::row_t row_q;

    // index of the copy currently on the output
    logic [shift_buffer_pkg::KERNEL_H_WIDTH-1:0] shift_idx;

    logic take;       // downstream takes current beat
    logic is_last;    // current beat is the final shift of the row
    logic load;       // new row enters this cycle

    assign take    = shift_valid && shift_ready;
    assign is_last = (shift_idx == kernel_h_1);

    // empty, or the last copy leaves now, so back-to-back rows have no bubble
    assign row_ready = !shift_valid || (take && is_last);
    assign load      = row_valid && row_ready;

    // beat s = words s .. s+CONV_UNITS-1 of the original row
    // row_q has been shifted down s words by now, so the low words are the beat
    assign shift.data       = row_q[shift_buffer_pkg::CONV_UNITS-1:0];
    assign shift.last_shift = is_last;

    // control
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            shift_valid <= 1'b0;
            shift_idx   <= '0;
        end else begin
            if (load) begin
                shift_valid <= 1'b1;
                shift_idx   <= '0;                   // first copy unshifted
            end else if (take) begin
                if (is_last) begin
                    shift_valid <= 1'b0;             // row used up
                    shift_idx   <= '0;
                end else begin
                    shift_idx <= shift_idx + 1'b1;   // next copy
                end
            end
        end
    end

    // row data, shifted down one word per accepted beat
    always_ff @(posedge aclk) begin
        if (load) begin
            row_q <= row;
        end else if (take && !is_last) begin
            // top word filled with zero, never reaches the beat window
            row_q <= {shift_buffer_pkg::DATA_WIDTH'(0),
                      row_q[shift_buffer_pkg::ROW_WORDS-1:1]};
        end
    end

endmodule

// File: design/beat_tagger.sv
// beat_tagger: config capture, channel/block counters, output register with last, user and done
`timescale 1ns/1ps

module beat_tagger (
    input  logic                                          aclk,
    input  logic                                          rst_n,
    // job control
    input  logic                                          start,
    input  shift_buffer_pkg::conv_cfg_t                   cfg,
    output shift_buffer_pkg::conv_cfg_t                   active_cfg,
    output logic [shift_buffer_pkg::KERNEL_H_WIDTH-1:0]   kernel_h_1,
    // shifted beats in
    input  shift_buffer_pkg::shift_beat_t                 shift,
    input  logic                                          shift_valid,
    output logic                                          shift_ready,
    // output stream
    output shift_buffer_pkg::beat_t                       m_data,
    output logic                                          m_valid,
    input  logic                                          m_ready,
    output logic                                          m_last,
    output shift_buffer_pkg::beat_tag_t                   m_user,
    output logic                                          done
);

    shift_buffer_pkg::conv_cfg_t cfg_q;   // configuration in force

    logic [shift_buffer_pkg::CIN_WIDTH-1:0]    cin_count;   // channel of incoming row
    logic [shift_buffer_pkg::BLOCKS_WIDTH-1:0] blk_count;   // block of incoming beat
    logic [shift_buffer_pkg::BLOCKS_WIDTH-1:0] blocks_2_idx;

    logic in_fire;      // beat moves into output register
    logic out_fire;     // output beat taken downstream
    logic last_in;      // incoming beat closes a channel group
    logic final_in;     // incoming beat closes the whole job
    logic final_q;      // registered with the beat, marks job end

    shift_buffer_pkg::beat_tag_t tag_in;

    assign active_cfg = cfg_q;
    assign kernel_h_1 = cfg_q.kernel_h_1;

    // single register stage, refill while draining
    assign shift_ready = !m_valid || m_ready;
    assign in_fire     = shift_valid && shift_ready;
    assign out_fire    = m_valid && m_ready;

    assign last_in  = shift.last_shift && (cin_count == cfg_q.cin_1);
    assign final_in = last_in && (blk_count == cfg_q.blocks_1);

    // blocks_1 - floor(kernel_w_1 / 2), wraps in counter width
    assign blocks_2_idx = cfg_q.blocks_1
                        - shift_buffer_pkg::BLOCKS_WIDTH'(cfg_q.kernel_w_1 >> 1);

    always_comb begin
        tag_in.is_1x1      = (cfg_q.kernel_h_1 == '0);
        tag_in.is_max      = cfg_q.is_max;
        tag_in.is_relu     = cfg_q.is_relu;
        tag_in.is_blocks_2 = (blk_count == blocks_2_idx);
    end

    // configuration, held until next start
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cfg_q <= shift_buffer_pkg::CFG_RESET;
        end else if (start) begin
            cfg_q <= cfg;
        end
    end

    // channel and block counters, both counted on the way into the register
    // so the block index is already settled for the next beat
    always_ff @(posedge aclk) begin
        if (!rst_n || start) begin
            cin_count <= '0;
            blk_count <= '0;
        end else if (in_fire && shift.last_shift) begin
            if (last_in) begin
                cin_count <= '0;   // group done
                if (blk_count == cfg_q.blocks_1) begin
                    blk_count <= '0;
                end else begin
                    blk_count <= blk_count + 1'b1;
                end
            end else begin
                cin_count <= cin_count + 1'b1;
            end
        end
    end

    // output control
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
            m_user  <= '0;
            final_q <= 1'b0;
        end else if (in_fire) begin
            m_valid <= 1'b1;
            m_last  <= last_in;
            m_user  <= tag_in;
            final_q <= final_in;
        end else if (out_fire) begin
            m_valid <= 1'b0;   // empty, nothing new
        end
    end

    // output payload
    always_ff @(posedge aclk) begin
        if (in_fire) begin
            m_data <= shift.data;
        end
    end

    // done level, set by the last beat of the last block
    always_ff @(posedge aclk) begin
        if (!rst_n || start) begin
            done <= 1'b0;
        end else if (out_fire && m_last && final_q) begin
            done <= 1'b1;
        end
    end

endmodule

// File: design/axis_shift_buffer.sv
// axis_shift_buffer: top level joining skid buffer, row shifter and beat tagger
`timescale 1ns/1ps

module axis_shift_buffer (
    input  logic                          aclk,
    input  logic                          rst_n,
    // job control
    input  logic                          start,     // one-cycle pulse, samples cfg
    input  shift_buffer_pkg::conv_cfg_t   cfg,
    output logic                          done,
    // padded rows in
    input  shift_buffer_pkg::row_t        s_row,
    input  logic                          s_valid,
    output logic                          s_ready,
    // shifted beats out
    output shift_buffer_pkg::beat_t       m_data,
    output logic                          m_valid,
    input  logic                          m_ready,
    output logic                          m_last,
    output shift_buffer_pkg::beat_tag_t   m_user,
    output shift_buffer_pkg::conv_cfg_t   active_cfg
);

    // skid buffer to shifter
    shift_buffer_pkg::row_t row;
    logic                   row_valid;
    logic                   row_ready;

    // shifter to tagger
    shift_buffer_pkg::shift_beat_t shift;
    logic                          shift_valid;
    logic                          shift_ready;

    logic [shift_buffer_pkg::KERNEL_H_WIDTH-1:0] kernel_h_1;   // from captured cfg

    row_skid_buffer skid_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .s_row     (s_row),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .row       (row),
        .row_valid (row_valid),
        .row_ready (row_ready)
    );

    row_shifter shifter_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .row         (row),
        .row_valid   (row_valid),
        .row_ready   (row_ready),
        .kernel_h_1  (kernel_h_1),
        .shift       (shift),
        .shift_valid (shift_valid),
        .shift_ready (shift_ready)
    );

    beat_tagger tagger_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .active_cfg  (active_cfg),
        .kernel_h_1  (kernel_h_1),
        .shift       (shift),
        .shift_valid (shift_valid),
        .shift_ready (shift_ready),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_last      (m_last),
        .m_user      (m_user),
        .done        (done)
    );

endmodule

// File: tests/tb_row_model.svh
// expected-beat queue, random row builder and beat/tag prediction for the shift buffer testbench
`ifndef TB_ROW_MODEL_SVH
`define TB_ROW_MODEL_SVH

// one predicted output beat with its tags
typedef struct packed {
    shift_buffer_pkg::beat_t     data;
    logic                        last;      // end of channel group
    shift_buffer_pkg::beat_tag_t user;
    logic                        job_end;   // m_last beat of the final block
} exp_beat_t;

exp_beat_t exp_q[$];             // beats still to come, oldest first
exp_beat_t exp_head = '0;        // what the output should be showing now
logic      have_exp = 1'b0;      // queue not empty

// padded row of random words
function automatic shift_buffer_pkg::row_t random_row();
    shift_buffer_pkg::row_t r;
    for (int w = 0; w < shift_buffer_pkg::ROW_WORDS; w++) begin
        r[w] = shift_buffer_pkg::DATA_WIDTH'($urandom);
    end
    return r;
endfunction

// beat s of row number row_idx within the job
function automatic exp_beat_t predict_beat(shift_buffer_pkg::row_t r, int s, int row_idx,
                                           shift_buffer_pkg::conv_cfg_t c);
    exp_beat_t e;
    int        cin;
    int        blocks;
    int        chan;
    int        blk;
    cin    = int'(c.cin_1) + 1;
    blocks = int'(c.blocks_1) + 1;
    chan   = row_idx % cin;               // channel of this row in its group
    blk    = (row_idx / cin) % blocks;    // one block per channel group
    for (int w = 0; w < shift_buffer_pkg::CONV_UNITS; w++) begin
        e.data[w] = r[s + w];             // window moves up s words
    end
    e.last             = (s == int'(c.kernel_h_1)) && (chan == cin - 1);
    e.user.is_1x1      = (c.kernel_h_1 == 0);
    e.user.is_max      = c.is_max;
    e.user.is_relu     = c.is_relu;
    e.user.is_blocks_2 = (blk == int'(c.blocks_1) - int'(c.kernel_w_1) / 2);
    e.job_end          = e.last && (blk == blocks - 1);
    return e;
endfunction

// queue all kernel_h copies of an accepted row
task automatic push_row(shift_buffer_pkg::row_t r, int row_idx, shift_buffer_pkg::conv_cfg_t c);
    for (int s = 0; s <= int'(c.kernel_h_1); s++) begin
        exp_q.push_back(predict_beat(r, s, row_idx, c));
    end
    exp_head = exp_q[0];
    have_exp = 1'b1;
endtask

// drop the head after an output transfer
task automatic pop_expected();
    void'(exp_q.pop_front());
    have_exp = (exp_q.size() != 0);
    if (have_exp) begin
        exp_head = exp_q[0];
    end
endtask

`endif

// File: tests/tb_axis_shift_buffer.sv
// testbench for axis_shift_buffer: clock, reset, job and row stimulus, output checks, timeout
`timescale 1ns/1ps

module tb_axis_shift_buffer;

    // 6 jobs, 58 rows, 134 beats; stalls and row gaps at most triple that,
    // plus reset and start overhead, so 4000 cycles is a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                          aclk;
    logic                          rst_n;
    logic                          start;
    shift_buffer_pkg::conv_cfg_t   cfg;
    logic                          done;
    shift_buffer_pkg::row_t        s_row;
    logic                          s_valid;
    logic                          s_ready;
    shift_buffer_pkg::beat_t       m_data;
    logic                          m_valid;
    logic                          m_ready;
    logic                          m_last;
    shift_buffer_pkg::beat_tag_t   m_user;
    shift_buffer_pkg::conv_cfg_t   active_cfg;

    int   errors       = 0;
    int   tests_run    = 0;
    int   tests_bad    = 0;
    int   cycle_count  = 0;
    logic random_stall = 1'b0;   // random m_ready and row gaps
    logic done_exp     = 1'b0;   // predicted done level

    `include "tb_row_model.svh"

    axis_shift_buffer dut_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .done       (done),
        .s_row      (s_row),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_data     (m_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_last     (m_last),
        .m_user     (m_user),
        .active_cfg (active_cfg)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;   // 10 ns period
    end

    // one rising edge plus the drive offset
    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    // converts plain values to the minus-one fields
    function automatic shift_buffer_pkg::conv_cfg_t job_cfg(int kh, int kw, bit mx, bit rl,
                                                            int cin, int blocks);
        shift_buffer_pkg::conv_cfg_t c;
        c.kernel_h_1 = shift_buffer_pkg::KERNEL_H_WIDTH'(kh - 1);
        c.kernel_w_1 = shift_buffer_pkg::KERNEL_W_WIDTH'(kw - 1);
        c.is_max     = mx;
        c.is_relu    = rl;
        c.cin_1      = shift_buffer_pkg::CIN_WIDTH'(cin - 1);
        c.blocks_1   = shift_buffer_pkg::BLOCKS_WIDTH'(blocks - 1);
        return c;
    endfunction

    // pop the model on each output transfer and track done
    always @(posedge aclk) begin
        if (!rst_n) begin
            done_exp <= 1'b0;
        end else begin
            if (start) begin
                done_exp <= 1'b0;
            end else if (m_valid && m_ready && have_exp && exp_head.job_end) begin
                done_exp <= 1'b1;   // final m_last taken
            end
            if (m_valid && m_ready && have_exp) begin
                pop_expected();
            end
        end
    end

    extra_beat: assert property (@(posedge aclk) disable iff (!rst_n) m_valid |-> have_exp)
        else begin
            errors++;
            $display("output beat at %0t arrived with no beat left to expect", $time);
        end

    data_check: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && have_exp |-> m_data == exp_head.data)
        else begin
            errors++;
            $display("ERROR %0t: beat data %h, expected %h", $time,
                     $sampled(m_data), $sampled(exp_head.data));
        end

    tag_check: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && have_exp |-> m_last == exp_head.last && m_user == exp_head.user)
        else begin
            errors++;
            $display("ERROR %0t: last/user %b/%b, expected %b/%b", $time, $sampled(m_last),
                     $sampled(m_user), $sampled(exp_head.last), $sampled(exp_head.user));
        end

    hold_check: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last)
                                && $stable(m_user))
        else begin
            errors++;
            $display("ERROR %0t: output changed while stalled", $time);
        end

    done_check: assert property (@(posedge aclk) disable iff (!rst_n) done == done_exp)
        else begin
            errors++;
            $display("ERROR %0t: done %b, expected %b", $time, $sampled(done),
                     $sampled(done_exp));
        end

    task automatic start_job(shift_buffer_pkg::conv_cfg_t c);
        start = 1'b1;
        cfg   = c;
        next_cycle();
        start = 1'b0;
        cfg   = ~c;   // only the captured copy may steer the job now
    endtask

    // hold the row until s_ready and queue its beats at the transfer
    task automatic send_row(shift_buffer_pkg::row_t r, int row_idx,
                            shift_buffer_pkg::conv_cfg_t c);
        s_row   = r;
        s_valid = 1'b1;
        while (!s_ready) begin
            next_cycle();
        end
        push_row(r, row_idx, c);   // transfer on the coming edge
        next_cycle();
        s_valid = 1'b0;
    endtask

    // one complete job of cin * blocks rows then a wait for done
    task automatic run_job(string name, shift_buffer_pkg::conv_cfg_t c, bit stalls);
        int rows;
        int errors_before;
        rows          = (int'(c.cin_1) + 1) * (int'(c.blocks_1) + 1);
        errors_before = errors;
        random_stall  = stalls;
        start_job(c);
        assert (active_cfg == c)
            else begin
                errors++;
                $display("ERROR %0t: active_cfg %h, expected %h", $time, active_cfg, c);
            end
        for (int i = 0; i < rows; i++) begin
            if (stalls) begin
                repeat ($urandom_range(0, 2)) next_cycle();   // gaps in s_valid
            end
            send_row(random_row(), i, c);
        end
        while (!done) begin
            next_cycle();
        end
        assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("%0d expected beats never reached the output", exp_q.size());
            end
        random_stall = 1'b0;
        tests_run++;
        if (errors != errors_before) begin
            tests_bad++;
        end
        $display("test %0d %s: %s", tests_run, name,
                 (errors == errors_before) ? "ok" : "errors seen");
    endtask

    initial begin
        m_ready = 1'b1;
        forever begin
            next_cycle();
            m_ready = random_stall ? ($urandom_range(0, 2) != 0) : 1'b1;
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha5cf));
        rst_n   = 1'b0;
        start   = 1'b0;
        cfg     = '0;
        s_row   = '0;
        s_valid = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        // idle state and 2x2 default config
        assert (s_ready && !m_valid && !m_last && !done
                && active_cfg == job_cfg(2, 2, 0, 0, 1, 1))
            else begin
                errors++;
                $display("ERROR %0t: state after reset is not idle", $time);
            end
        run_job("kernel_h 3 shifts",  job_cfg(3, 1, 0, 0, 1, 6), 1'b0);
        run_job("kernel_h 1 is_1x1",  job_cfg(1, 1, 0, 0, 1, 8), 1'b0);
        run_job("cin 4 last and max", job_cfg(2, 2, 1, 0, 4, 2), 1'b0);
        run_job("blocks 4 kw 3 flag", job_cfg(2, 3, 0, 1, 2, 4), 1'b0);
        run_job("done level",         job_cfg(1, 1, 0, 0, 2, 2), 1'b0);
        run_job("random stalls",      job_cfg(3, 2, 1, 1, 3, 8), 1'b1);
        $display("tests run %0d, tests with errors %0d, error count %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+tests
design/shift_buffer_pkg.sv
design/row_skid_buffer.sv
design/row_shifter.sv
design/beat_tagger.sv
design/axis_shift_buffer.sv
tests/tb_axis_shift_buffer.sv

// File: Bender.yml
package:
  name: axis_shift_buffer

sources:
  # package first, then the three stages, then the top level
  - design/shift_buffer_pkg.sv
  - design/row_skid_buffer.sv
  - design/row_shifter.sv
  - design/beat_tagger.sv
  - design/axis_shift_buffer.sv
  # testbench, its model header lives in tests
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_axis_shift_buffer.sv
